// ==== Bender.yml ====
package:
  name: mips_core

export_include_dirs:
  - .

sources:
  - mips_pkg.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_assertions.sv
      - tb_mips_core.sv

// ==== decode_stage.sv ====
// decode stage: IF/ID register, control decode, register read, load-use stall and ID/EX register
`timescale 1ns/100ps
`include "mips_consts.svh"

module decode_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  mips_pkg::fetch_t   fetch,
    output logic               ready,
    input  mips_pkg::ex_mem_t  ex_mem,
    input  mips_pkg::commit_t  wb,
    output mips_pkg::id_ex_t   id_ex
);
    logic                    ifid_valid_q;
    mips_pkg::instr_t        ifid_instr_q;
    mips_pkg::ctrl_t         ctrl;
    logic [`MIPS_REG_AW-1:0] dest;
    logic                    use_rs;
    logic                    use_rt;
    logic [`MIPS_XLEN-1:0]   rs_val;
    logic [`MIPS_XLEN-1:0]   rt_val;
    logic                    stall;
    mips_pkg::id_ex_t        id_ex_nxt;
    mips_pkg::id_ex_t        id_ex_data_q;
    mips_pkg::ctrl_t         id_ex_ctrl_q;

    // IF/ID holds while stalled
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ifid_valid_q <= 1'b0;
        else if (ready)
            ifid_valid_q <= fetch.valid;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (ready)
            ifid_instr_q <= fetch.instr;
    end

    always_comb
    begin
        ctrl   = '0;
        use_rs = 1'b0;
        use_rt = 1'b0;
        dest   = ifid_instr_q.i_fmt.rt;  // rt unless r-type
        if (ifid_valid_q)
        begin
            case (ifid_instr_q.r_fmt.opcode)
                `MIPS_OP_RTYPE:
                begin
                    dest           = ifid_instr_q.r_fmt.rd;
                    use_rs         = 1'b1;
                    use_rt         = 1'b1;
                    ctrl.reg_write = 1'b1;
                    case (ifid_instr_q.r_fmt.funct)
                        `MIPS_FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                        `MIPS_FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                        `MIPS_FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                        `MIPS_FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                        `MIPS_FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
                        default:      ctrl.reg_write = 1'b0;  // unknown funct is a no-op
                    endcase
                end
                `MIPS_OP_ADDI:
                begin
                    use_rs           = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                `MIPS_OP_LW:
                begin
                    use_rs           = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                `MIPS_OP_SW:
                begin
                    use_rs           = 1'b1;
                    use_rt           = 1'b1;  // store data
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                default: ;
            endcase
        end
        if (dest == '0)
            ctrl.reg_write = 1'b0;  // r0 writes never commit
    end

    reg_file i_reg_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (ifid_instr_q.i_fmt.rs),
        .rt_addr   (ifid_instr_q.i_fmt.rt),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .wb        (wb)
    );

    // a load still in execute cannot forward yet, so hold one cycle
    assign stall = id_ex.ctrl.mem_read && id_ex.dest != '0 &&
                   ((use_rs && id_ex.dest == ifid_instr_q.i_fmt.rs) ||
                    (use_rt && id_ex.dest == ifid_instr_q.i_fmt.rt));
    assign ready = ~stall;

    always_comb
    begin
        id_ex_nxt.ctrl    = stall ? '0 : ctrl;  // bubble during stall
        id_ex_nxt.rs      = ifid_instr_q.i_fmt.rs;
        id_ex_nxt.rt      = ifid_instr_q.i_fmt.rt;
        id_ex_nxt.dest    = dest;
        id_ex_nxt.rs_val  = rs_val;
        id_ex_nxt.rt_val  = rt_val;
        id_ex_nxt.imm_ext = {{(`MIPS_XLEN-`MIPS_IMM_W){ifid_instr_q.i_fmt.imm[`MIPS_IMM_W-1]}},
                             ifid_instr_q.i_fmt.imm};
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex_ctrl_q <= '0;
        else
            id_ex_ctrl_q <= id_ex_nxt.ctrl;
    end

    always_ff @(posedge SYS_clk)
    begin
        id_ex_data_q <= id_ex_nxt;
    end

    always_comb
    begin
        id_ex      = id_ex_data_q;
        id_ex.ctrl = id_ex_ctrl_q;
    end

endmodule

// ==== execute_stage.sv ====
// execute stage: operand forwarding, ALU and the EX/MEM register
`timescale 1ns/100ps
`include "mips_consts.svh"

module execute_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  mips_pkg::id_ex_t   id_ex,
    input  mips_pkg::commit_t  wb,
    output mips_pkg::ex_mem_t  ex_mem
);
    logic [`MIPS_XLEN-1:0] op_a;
    logic [`MIPS_XLEN-1:0] rt_fwd;
    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    mips_pkg::ctrl_t       ex_mem_ctrl_q;
    mips_pkg::ex_mem_t     ex_mem_data_q;

    // newest producer wins, r0 never forwarded
    function automatic logic [`MIPS_XLEN-1:0] fwd(
        input logic [`MIPS_REG_AW-1:0] src,
        input logic [`MIPS_XLEN-1:0]   reg_val,
        input mips_pkg::ex_mem_t       em,
        input mips_pkg::commit_t       wr
    );
        if (src == '0)
            return reg_val;
        if (em.ctrl.reg_write && em.dest == src)
            return em.alu_result;
        if (wr.valid && wr.rd == src)
            return wr.data;
        return reg_val;
    endfunction

    assign op_a   = fwd(id_ex.rs, id_ex.rs_val, ex_mem, wb);
    assign rt_fwd = fwd(id_ex.rt, id_ex.rt_val, ex_mem, wb);
    assign op_b   = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : rt_fwd;

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_result = op_a + op_b;
            mips_pkg::ALU_SUB: alu_result = op_a - op_b;
            mips_pkg::ALU_AND: alu_result = op_a & op_b;
            mips_pkg::ALU_OR:  alu_result = op_a | op_b;
            mips_pkg::ALU_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}},
                                             $signed(op_a) < $signed(op_b)};  // signed compare
            default:           alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem_ctrl_q <= '0;
        else
            ex_mem_ctrl_q <= id_ex.ctrl;
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_mem_data_q.ctrl       <= id_ex.ctrl;
        ex_mem_data_q.dest       <= id_ex.dest;
        ex_mem_data_q.alu_result <= alu_result;
        ex_mem_data_q.store_data <= rt_fwd;  // forwarded rt for sw
    end

    always_comb
    begin
        ex_mem      = ex_mem_data_q;
        ex_mem.ctrl = ex_mem_ctrl_q;
    end

endmodule

// ==== memory_stage.sv ====
// memory stage: word-addressed data memory and the MEM/WB register that drives commit
`timescale 1ns/100ps
`include "mips_consts.svh"

module memory_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  mips_pkg::ex_mem_t  ex_mem,
    output mips_pkg::commit_t  wb
);
    logic [`MIPS_XLEN-1:0]    dmem [`MIPS_DMEM_WORDS];
    logic [`MIPS_DMEM_AW-1:0] addr;
    logic [`MIPS_XLEN-1:0]    rd_data;
    logic                     wb_valid_q;
    logic [`MIPS_REG_AW-1:0]  wb_rd_q;
    logic [`MIPS_XLEN-1:0]    wb_data_q;

    assign addr    = ex_mem.alu_result[`MIPS_DMEM_AW+1:2];  // drop byte offset
    assign rd_data = dmem[addr];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++)
                dmem[i] <= '0;
        end
        else if (ex_mem.ctrl.mem_write)
        begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            wb_valid_q <= 1'b0;
        else
            wb_valid_q <= ex_mem.ctrl.reg_write;
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_rd_q   <= ex_mem.dest;
        wb_data_q <= ex_mem.ctrl.mem_read ? rd_data : ex_mem.alu_result;  // load word or alu
    end

    assign wb = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q};

endmodule

// ==== mips_consts.svh ====
// widths, opcodes, funct codes and memory depth shared by the package, the RTL and the testbench
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_XLEN        32  // data and instruction width
`define MIPS_REG_AW      5   // register address width
`define MIPS_OP_W        6   // opcode and funct field width
`define MIPS_IMM_W       16  // i-format immediate width
`define MIPS_DMEM_WORDS  64  // data memory depth in words
`define MIPS_DMEM_AW     6   // data memory word address width

// opcodes
`define MIPS_OP_RTYPE    6'h00
`define MIPS_OP_ADDI     6'h08
`define MIPS_OP_LW       6'h23
`define MIPS_OP_SW       6'h2b

// funct codes for r-type
`define MIPS_FN_ADD      6'h20
`define MIPS_FN_SUB      6'h22
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_SLT      6'h2a

`endif

// ==== mips_core.sv ====
// top of the five-stage pipeline, taking an instruction stream and reporting register commits
`timescale 1ns/100ps

module mips_core (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  mips_pkg::fetch_t   fetch,
    output logic               ready,
    output mips_pkg::commit_t  commit
);
    mips_pkg::id_ex_t  id_ex;
    mips_pkg::ex_mem_t ex_mem;

    decode_stage i_decode (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .fetch     (fetch),
        .ready     (ready),
        .ex_mem    (ex_mem),
        .wb        (commit),  // register file write
        .id_ex     (id_ex)
    );

    execute_stage i_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .id_ex     (id_ex),
        .wb        (commit),  // second forwarding source
        .ex_mem    (ex_mem)
    );

    memory_stage i_memory (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (ex_mem),
        .wb        (commit)
    );

endmodule

// ==== mips_core_assertions.sv ====
// concurrent checks on the stream and commit ports, bound into mips_core from the testbench
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_core_assertions (
    input logic              SYS_clk,
    input logic              SYS_reset,
    input mips_pkg::fetch_t  fetch,
    input logic              ready,
    input mips_pkg::commit_t commit
);
    logic                    accept_wr;    // accepted this cycle and writes a register
    logic [`MIPS_REG_AW-1:0] accept_dest;

    always_comb
    begin
        accept_wr   = 1'b0;
        accept_dest = fetch.instr.i_fmt.rt;
        case (fetch.instr.r_fmt.opcode)
            `MIPS_OP_RTYPE:
            begin
                accept_dest = fetch.instr.r_fmt.rd;
                accept_wr   = fetch.instr.r_fmt.funct inside {`MIPS_FN_ADD, `MIPS_FN_SUB,
                              `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_SLT};
            end
            `MIPS_OP_ADDI, `MIPS_OP_LW: accept_wr = 1'b1;
            default: ;
        endcase
        if (!fetch.valid || !ready || accept_dest == '0)
            accept_wr = 1'b0;
    end

    ready_after_reset: assert property (@(posedge SYS_clk)
        $fell(SYS_reset) |-> ready && !commit.valid)
        else $error("ready low or commit valid just after reset");

    no_r0_commit: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit.valid |-> commit.rd != '0)
        else $error("commit to register 0");

    single_stall: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !ready |=> ready)
        else $error("ready low for more than one cycle");

    // no stall behind it, so commit lands four cycles after acceptance
    fixed_latency: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        accept_wr ##1 ready |-> ##3 (commit.valid && commit.rd == $past(accept_dest, 4)))
        else $error("independent instruction did not commit four cycles after acceptance");

endmodule

// ==== mips_pkg.sv ====
// instruction, control and stage-boundary types, referenced by scoped name from the core and testbench
`include "mips_consts.svh"

package mips_pkg;

    typedef struct packed {
        logic [`MIPS_OP_W-1:0]   opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_REG_AW-1:0] shamt;
        logic [`MIPS_OP_W-1:0]   funct;
    } r_fmt_t;

    typedef struct packed {
        logic [`MIPS_OP_W-1:0]   opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_IMM_W-1:0]  imm;
    } i_fmt_t;

    // one instruction word seen through both decodings
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;  // second operand is the immediate
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] dest;
        logic [`MIPS_XLEN-1:0]   rs_val;
        logic [`MIPS_XLEN-1:0]   rt_val;
        logic [`MIPS_XLEN-1:0]   imm_ext;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`MIPS_REG_AW-1:0] dest;
        logic [`MIPS_XLEN-1:0]   alu_result;  // also the load/store byte address
        logic [`MIPS_XLEN-1:0]   store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_XLEN-1:0]   data;
    } commit_t;

endpackage

// ==== reg_file.sv ====
// 32-entry register file with two read ports and one write port fed by the write-back commit
`timescale 1ns/100ps
`include "mips_consts.svh"

module reg_file (
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  logic [`MIPS_REG_AW-1:0] rs_addr,
    input  logic [`MIPS_REG_AW-1:0] rt_addr,
    output logic [`MIPS_XLEN-1:0]   rs_val,
    output logic [`MIPS_XLEN-1:0]   rt_val,
    input  mips_pkg::commit_t       wb
);
    logic [`MIPS_XLEN-1:0] regs [2**`MIPS_REG_AW];

    // write-through so decode sees the value being written this cycle
    function automatic logic [`MIPS_XLEN-1:0] read_port(
        input logic [`MIPS_REG_AW-1:0] addr,
        input logic [`MIPS_XLEN-1:0]   stored,
        input mips_pkg::commit_t       wr
    );
        if (addr == '0)
            return '0;  // r0 hardwired
        if (wr.valid && wr.rd == addr)
            return wr.data;
        return stored;
    endfunction

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**`MIPS_REG_AW; i++)
                regs[i] <= '0;
        end
        else if (wb.valid && wb.rd != '0)
        begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs_val = read_port(rs_addr, regs[rs_addr], wb);
    assign rt_val = read_port(rt_addr, regs[rt_addr], wb);

endmodule

// ==== tb.f ====
+incdir+.
mips_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
mips_core_assertions.sv
tb_mips_core.sv

// ==== tb_mips_core.sv ====
// self-checking testbench for mips_core: runs an LFSR-built random program against a model
`timescale 1ns/100ps
`include "mips_consts.svh"

module tb_mips_core;

    localparam int NUM_INSTR   = 300;
    localparam int CYCLE_LIMIT = NUM_INSTR * 3 + 100;

    logic                  SYS_clk;
    logic                  SYS_reset;
    mips_pkg::fetch_t      fetch;
    logic                  ready;
    mips_pkg::commit_t     commit;

    logic [31:0]           lfsr_state;
    mips_pkg::instr_t      prog [NUM_INSTR];
    logic                  gap  [NUM_INSTR];  // idle cycle before this instruction
    logic [`MIPS_XLEN-1:0] arch_regs [2**`MIPS_REG_AW];
    logic [`MIPS_XLEN-1:0] arch_mem  [`MIPS_DMEM_WORDS];
    mips_pkg::commit_t     exp_q [$];
    int                    cycle_cnt;
    int                    stall_cycle;  // cycle in which ready must be low
    int                    accepted;
    int                    expected_commits;
    int                    commits_seen;

    mips_core i_dut (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .fetch     (fetch),
        .ready     (ready),
        .commit    (commit)
    );

    bind mips_core mips_core_assertions i_assertions (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .fetch     (fetch),
        .ready     (ready),
        .commit    (commit)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 32'h80200003;  // galois taps
        return b;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[14:0], lfsr_bit()};
        return v;
    endfunction

    function automatic mips_pkg::instr_t gen_instr();
        mips_pkg::instr_t ins;
        logic [3:0]       kind;
        logic [2:0]       fsel;
        logic [15:0]      r;
        ins          = '0;
        kind         = 4'(rand_bits(4));
        ins.i_fmt.rs = 5'(rand_bits(3));  // registers 0 to 7 only
        ins.i_fmt.rt = 5'(rand_bits(3));
        if (kind <= 4'd6)
        begin
            ins.r_fmt.opcode = `MIPS_OP_RTYPE;
            ins.r_fmt.rd     = 5'(rand_bits(3));
            fsel             = 3'(rand_bits(3));
            case (fsel)
                3'd0:       ins.r_fmt.funct = `MIPS_FN_ADD;
                3'd1, 3'd6: ins.r_fmt.funct = `MIPS_FN_SUB;
                3'd2:       ins.r_fmt.funct = `MIPS_FN_AND;
                3'd3:       ins.r_fmt.funct = `MIPS_FN_OR;
                3'd4, 3'd5: ins.r_fmt.funct = `MIPS_FN_SLT;
                default:    ins.r_fmt.funct = 6'h27;  // nor, not supported
            endcase
        end
        else if (kind <= 4'd9)
        begin
            ins.i_fmt.opcode = `MIPS_OP_ADDI;
            r                = rand_bits(6);
            ins.i_fmt.imm    = {{10{r[5]}}, r[5:0]};  // small signed immediate
        end
        else if (kind <= 4'd13)
        begin
            ins.i_fmt.opcode = (kind <= 4'd11) ? `MIPS_OP_LW : `MIPS_OP_SW;
            ins.i_fmt.rs     = '0;
            r                = rand_bits(6);
            ins.i_fmt.imm    = {8'h00, r[5:0], 2'b00};  // word offset below 256
        end
        else if (kind == 4'd14)
        begin
            ins.i_fmt.opcode = 6'h3f;  // undefined opcode
            ins.i_fmt.rs     = '0;
            ins.i_fmt.rt     = '0;
            ins.i_fmt.imm    = rand_bits(16);
        end
        else
        begin
            ins.i_fmt.opcode = `MIPS_OP_ADDI;  // large constant
            ins.i_fmt.rs     = '0;
            ins.i_fmt.imm    = rand_bits(16);
        end
        return ins;
    endfunction

    // source registers an instruction reads in decode
    function automatic logic reads_reg(input mips_pkg::instr_t ins, input logic [4:0] r);
        if (r == '0)
            return 1'b0;
        case (ins.r_fmt.opcode)
            `MIPS_OP_RTYPE, `MIPS_OP_SW: return ins.i_fmt.rs == r || ins.i_fmt.rt == r;
            `MIPS_OP_ADDI, `MIPS_OP_LW:  return ins.i_fmt.rs == r;
            default:                     return 1'b0;
        endcase
    endfunction

    task automatic run_model(input mips_pkg::instr_t ins);
        logic [`MIPS_XLEN-1:0] a;
        logic [`MIPS_XLEN-1:0] b;
        logic [`MIPS_XLEN-1:0] imm;
        logic [`MIPS_XLEN-1:0] addr;
        logic [`MIPS_XLEN-1:0] res;
        logic [4:0]            dst;
        logic                  wr;
        a    = arch_regs[ins.i_fmt.rs];
        b    = arch_regs[ins.i_fmt.rt];
        imm  = {{16{ins.i_fmt.imm[15]}}, ins.i_fmt.imm};
        addr = a + imm;
        res  = '0;
        dst  = ins.i_fmt.rt;
        wr   = 1'b1;
        case (ins.r_fmt.opcode)
            `MIPS_OP_RTYPE:
            begin
                dst = ins.r_fmt.rd;
                case (ins.r_fmt.funct)
                    `MIPS_FN_ADD: res = a + b;
                    `MIPS_FN_SUB: res = a - b;
                    `MIPS_FN_AND: res = a & b;
                    `MIPS_FN_OR:  res = a | b;
                    `MIPS_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:      wr  = 1'b0;
                endcase
            end
            `MIPS_OP_ADDI: res = a + imm;
            `MIPS_OP_LW:   res = arch_mem[addr[7:2]];
            `MIPS_OP_SW:
            begin
                arch_mem[addr[7:2]] = b;
                wr                  = 1'b0;
            end
            default:       wr  = 1'b0;
        endcase
        if (wr && dst != '0)
        begin
            arch_regs[dst] = res;
            exp_q.push_back('{valid: 1'b1, rd: dst, data: res});
            expected_commits++;
        end
    endtask

    task automatic compare_commit(input mips_pkg::commit_t got, input mips_pkg::commit_t exp);
        if (got !== exp)
            fail_now($sformatf("MISMATCH at %0t: commit r%0d=%h, model expects r%0d=%h",
                               $time, got.rd, got.data, exp.rd, exp.data));
    endtask

    task automatic compare_ready(input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("MISMATCH at %0t: ready is %b, model expects %b",
                               $time, got, exp));
    endtask

    task automatic count_accept(input mips_pkg::fetch_t f, input logic rdy, output logic taken);
        if ($isunknown(rdy))
            fail_now("ready is unknown while the stream is being driven");
        taken = f.valid && rdy;
        if (taken)
            accepted++;
    endtask

    initial
    begin
        SYS_clk = 1'b0;
        forever #2 SYS_clk = ~SYS_clk;
    end

    initial
    begin
        cycle_cnt = 0;
        forever
        begin
            @(posedge SYS_clk);
            if (!SYS_reset)
                cycle_cnt++;
            if (cycle_cnt >= CYCLE_LIMIT)
                fail_now("timeout: the program did not finish within the cycle limit");
        end
    end

    // commit and ready are registered outputs, stable at the falling edge
    initial
    begin
        @(negedge SYS_reset);
        forever
        begin
            @(negedge SYS_clk);
            compare_ready(ready, stall_cycle != cycle_cnt);
            if (commit.valid)
            begin
                if (exp_q.size() == 0)
                    fail_now("a commit arrived with no register write outstanding");
                else
                    compare_commit(commit, exp_q.pop_front());
                commits_seen++;
            end
        end
    end

    initial
    begin
        mips_pkg::instr_t last_instr;
        int               last_edge;
        int               idx;
        logic             taken;
        logic             gap_done;
        SYS_reset        = 1'b1;
        fetch            = '0;
        lfsr_state       = 32'd11;
        stall_cycle      = -1;
        accepted         = 0;
        expected_commits = 0;
        commits_seen     = 0;
        last_instr       = '0;
        for (int i = 0; i < 2**`MIPS_REG_AW; i++)
            arch_regs[i] = '0;
        for (int i = 0; i < `MIPS_DMEM_WORDS; i++)
            arch_mem[i] = '0;
        for (int i = 0; i < NUM_INSTR; i++)
        begin
            prog[i] = gen_instr();
            gap[i]  = (rand_bits(2) == 16'd0);
        end
        repeat (8) @(posedge SYS_clk);
        #0.5;
        SYS_reset = 1'b0;
        idx       = 0;
        last_edge = -2;
        gap_done  = 1'b0;
        while (idx < NUM_INSTR)
        begin
            if (gap[idx] && !gap_done)
            begin
                fetch.valid = 1'b0;
                gap_done    = 1'b1;
            end
            else
            begin
                fetch.valid = 1'b1;  // held until accepted
                fetch.instr = prog[idx];
            end
            @(negedge SYS_clk);
            count_accept(fetch, ready, taken);
            @(posedge SYS_clk);
            #0.5;
            if (taken)
            begin
                // back-to-back load and reader of its result
                if (last_edge == cycle_cnt - 1 && last_instr.r_fmt.opcode == `MIPS_OP_LW &&
                    reads_reg(prog[idx], last_instr.i_fmt.rt))
                    stall_cycle = cycle_cnt;
                run_model(prog[idx]);
                last_instr = prog[idx];
                last_edge  = cycle_cnt;
                idx++;
                gap_done = 1'b0;
            end
        end
        fetch = '0;
        repeat (8) @(posedge SYS_clk);  // last commit due four cycles after acceptance
        if (accepted != NUM_INSTR || commits_seen != expected_commits)
            fail_now($sformatf("count wrong: %0d accepted, %0d commits, %0d expected",
                               accepted, commits_seen, expected_commits));
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
